// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module vReadTb -o vReadTb
	./obj_dir/vReadTb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
+incdir+logic
logic/vReadPkg.sv
logic/extAddrGen.sv
logic/addrGen2.sv
logic/dualPortRam.sv
logic/vRead.sv
tb/vRead_assert.sv
tb/vReadTb.sv

// File: logic/addrGen2.sv
`timescale 1ns/1ps
`default_nettype none

module addrGen2
   import vReadPkg::*;
(
   input  wire          clk,
   input  wire          arstN,

   input  wire          run,
   input  wire genCfg_t cfg,

   output memAddr_t     addr,
   output logic         memEn,
   output logic         genDone
);

   genState_t state;
   period_t   delayCnt;
   period_t   pCnt;
   memAddr_t  iCnt;
   memAddr_t  jCnt;
   memAddr_t  base2;
   memAddr_t  base1;
   memAddr_t  cur;
   logic      pLast;
   logic      iLast;
   logic      jLast;
   logic      empty;

   assign pLast = (pCnt == cfg.period - 1'b1);
   assign iLast = (iCnt == cfg.iterations - 1'b1);
   assign jLast = (jCnt == cfg.iterations2 - 1'b1);
   assign empty = (cfg.period == '0) || (cfg.iterations == '0) || (cfg.iterations2 == '0);

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state <= GEN_IDLE;
         delayCnt <= '0;
         pCnt <= '0;
         iCnt <= '0;
         jCnt <= '0;
         memEn <= 1'b0;
         genDone <= 1'b0;
      end
      else if (run)
      begin
         state <= GEN_DELAY;
         delayCnt <= cfg.delay;
         memEn <= 1'b0;
         genDone <= 1'b0;
      end
      else
      begin
         case (state)
            GEN_DELAY:
            begin
               memEn <= 1'b0;
               pCnt <= '0;
               iCnt <= '0;
               jCnt <= '0;
               if (empty)
               begin
                  state <= GEN_IDLE;
                  genDone <= 1'b1;
               end
               else if (delayCnt == '0)
                  state <= GEN_RUN;
               else
                  delayCnt <= delayCnt - 1'b1;
            end
            GEN_RUN:
            begin
               memEn <= 1'b1;
               // p fastest, then i, then j
               if (!pLast)
                  pCnt <= pCnt + 1'b1;
               else
               begin
                  pCnt <= '0;
                  if (!iLast)
                     iCnt <= iCnt + 1'b1;
                  else
                  begin
                     iCnt <= '0;
                     if (jLast)
                        state <= GEN_IDLE;
                     else
                        jCnt <= jCnt + 1'b1;
                  end
               end
            end
            default:
            begin
               // done follows the last issued address by one edge
               memEn <= 1'b0;
               genDone <= genDone | memEn;
            end
         endcase
      end
   end

   // running bases, adds only
   always_ff @(posedge clk)
   begin
      if (state == GEN_DELAY)
      begin
         base2 <= cfg.start;
         base1 <= cfg.start;
         cur <= cfg.start;
      end
      else if (state == GEN_RUN)
      begin
         addr <= cur;
         if (!pLast)
            cur <= cur + cfg.incr;
         else if (!iLast)
         begin
            base1 <= base1 + cfg.shift;
            cur <= base1 + cfg.shift;
         end
         else
         begin
            base2 <= base2 + cfg.incr2;
            base1 <= base2 + cfg.incr2;
            cur <= base2 + cfg.incr2;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/dualPortRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module dualPortRam
   import vReadPkg::*;
(
   input  wire           clk,

   input  wire           wrEn,
   input  wire memAddr_t wrAddr,
   input  wire data_t    wrData,

   input  wire           rdEn,
   input  wire memAddr_t rdAddr,
   output data_t         rdData
);

   data_t mem [0:(2**`VR_MEM_ADDR_W)-1];

   always_ff @(posedge clk)
   begin
      if (wrEn)
         mem[wrAddr] <= wrData;
      // read data holds while disabled
      if (rdEn)
         rdData <= mem[rdAddr];
   end

endmodule

`default_nettype wire

// File: logic/extAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module extAddrGen
   import vReadPkg::*;
(
   input  wire          clk,
   input  wire          arstN,

   input  wire          run,
   input  wire extCfg_t cfg,
   output logic         extDone,

   // external bus, read only
   input  wire          databusReady,
   output logic         databusValid,
   output ioAddr_t      databusAddr,
   input  wire data_t   databusRdata,

   // RAM write port
   output logic         wrEn,
   output memAddr_t     wrAddr,
   output data_t        wrData
);

   extState_t state;
   ioSize_t   cnt;
   ioAddr_t   extPtr;
   memAddr_t  intPtr;
   logic      xfer;
   logic      lastWord;

   // cnt only equals size while requesting when size is zero
   assign databusValid = (state == EXT_REQ) && (cnt != cfg.size);
   assign xfer = databusValid && databusReady;
   assign lastWord = (ioSize_t'(cnt + 1'b1) == cfg.size);

   assign databusAddr = extPtr;
   assign extDone = (state == EXT_DONE);

   // returned word goes straight into the RAM
   assign wrEn = xfer;
   assign wrAddr = intPtr;
   assign wrData = databusRdata;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state <= EXT_IDLE;
         cnt <= '0;
      end
      else if (run)
      begin
         state <= EXT_REQ;
         cnt <= '0;
      end
      else
      begin
         case (state)
            EXT_REQ:
            begin
               if (cnt == cfg.size)
               begin
                  state <= EXT_DONE;
               end
               else if (xfer)
               begin
                  cnt <= cnt + 1'b1;
                  if (lastWord)
                  begin
                     state <= EXT_DONE;
                  end
               end
            end
            EXT_DONE:
            begin
               // hold until the next run
               state <= EXT_DONE;
            end
            default:
            begin
               state <= EXT_IDLE;
            end
         endcase
      end
   end

   // word pointers, both sides step on each handshake
   always_ff @(posedge clk)
   begin
      if (run)
      begin
         extPtr <= cfg.extAddr;
         intPtr <= cfg.intAddr;
      end
      else if (xfer)
      begin
         extPtr <= extPtr + 1'b1;
         intPtr <= intPtr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: logic/vRead.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module vRead
   import vReadPkg::*;
(
   input  wire                     clk,
   input  wire                     arstN,

   input  wire                     run,
   output logic                    done,
   input  wire vReadCfg_t          cfg,

   // native bus
   input  wire                     databusReady,
   output logic                    databusValid,
   output ioAddr_t                 databusAddr,
   input  wire data_t              databusRdata,
   output data_t                   databusWdata,
   output logic [`VR_DATA_W/8-1:0] databusWstrb,

   output data_t                   out0
);

   logic     extDone;
   logic     genDone;
   logic     wrEn;
   memAddr_t wrAddr;
   data_t    wrData;
   logic     rdEn;
   memAddr_t genAddr;
   memAddr_t rdAddr;

   function automatic memAddr_t reverseBits(input memAddr_t a);
      memAddr_t r;
      for (int i = 0; i < `VR_MEM_ADDR_W; i++)
         r[i] = a[`VR_MEM_ADDR_W-1-i];
      return r;
   endfunction

   // read only unit
   assign databusWdata = '0;
   assign databusWstrb = '0;

   assign done = extDone & genDone;

   // FFT style reordering
   assign rdAddr = cfg.gen.reverse ? reverseBits(genAddr) : genAddr;

   extAddrGen extGen_i (
      .clk(clk),
      .arstN(arstN),
      .run(run),
      .cfg(cfg.ext),
      .extDone(extDone),
      .databusReady(databusReady),
      .databusValid(databusValid),
      .databusAddr(databusAddr),
      .databusRdata(databusRdata),
      .wrEn(wrEn),
      .wrAddr(wrAddr),
      .wrData(wrData)
   );

   addrGen2 rdGen_i (
      .clk(clk),
      .arstN(arstN),
      .run(run),
      .cfg(cfg.gen),
      .addr(genAddr),
      .memEn(rdEn),
      .genDone(genDone)
   );

   dualPortRam mem_i (
      .clk(clk),
      .wrEn(wrEn),
      .wrAddr(wrAddr),
      .wrData(wrData),
      .rdEn(rdEn),
      .rdAddr(rdAddr),
      .rdData(out0)
   );

endmodule

`default_nettype wire

// File: logic/vReadPkg.sv
`default_nettype none

`include "vread_defs.svh"

package vReadPkg;

   typedef logic [`VR_DATA_W-1:0]     data_t;
   typedef logic [`VR_IO_ADDR_W-1:0]  ioAddr_t;
   typedef logic [`VR_MEM_ADDR_W-1:0] memAddr_t;
   typedef logic [`VR_IO_SIZE_W-1:0]  ioSize_t;
   typedef logic [`VR_PERIOD_W-1:0]   period_t;

   // fetch side
   typedef struct packed {
      ioAddr_t  extAddr;
      memAddr_t intAddr;
      ioSize_t  size;
   } extCfg_t;

   // read side
   typedef struct packed {
      memAddr_t iterations;
      memAddr_t start;
      memAddr_t shift;
      memAddr_t incr;
      memAddr_t iterations2;
      memAddr_t incr2;
      period_t  period;
      period_t  delay;
      logic     reverse;
   } genCfg_t;

   typedef struct packed {
      extCfg_t ext;
      genCfg_t gen;
   } vReadCfg_t;

   typedef enum logic [1:0] {EXT_IDLE, EXT_REQ, EXT_DONE} extState_t;
   typedef enum logic [1:0] {GEN_IDLE, GEN_DELAY, GEN_RUN} genState_t;

endpackage

`default_nettype wire

// File: logic/vread_defs.svh
`ifndef VREAD_DEFS_SVH
`define VREAD_DEFS_SVH

// data word width
`define VR_DATA_W 32

// external bus word address width
`define VR_IO_ADDR_W 32

// internal RAM address, 256 words
`define VR_MEM_ADDR_W 8

// transfer size, one bit wider than the RAM address so a full RAM fits
`define VR_IO_SIZE_W 9

// period and start delay counters
`define VR_PERIOD_W 5

`endif

// File: tb/vReadTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module vReadTb
   import vReadPkg::*;
;

   localparam int TIMEOUT = 2000;
   localparam int NUM_ROWS = 8;

   typedef enum logic [1:0] {MODE_FILL, MODE_READ, MODE_ZERO} rowMode_t;

   typedef struct packed {
      rowMode_t  mode;
      vReadCfg_t cfg;
   } testRow_t;

   logic                    clk;
   logic                    arstN;
   logic                    run;
   logic                    done;
   vReadCfg_t               cfg;
   logic                    databusReady;
   logic                    databusValid;
   ioAddr_t                 databusAddr;
   data_t                   databusRdata;
   data_t                   databusWdata;
   logic [`VR_DATA_W/8-1:0] databusWstrb;
   data_t                   out0;

   data_t    extMem [0:1023];
   data_t    modelRam [0:255];
   data_t    expQ [$];
   testRow_t testTable [0:NUM_ROWS-1];

   int      errors;
   int      passed;
   int      failed;
   int      hsCount;
   logic    busAllowed;
   ioAddr_t busNext;

   vRead dut_i (
      .clk(clk),
      .arstN(arstN),
      .run(run),
      .done(done),
      .cfg(cfg),
      .databusReady(databusReady),
      .databusValid(databusValid),
      .databusAddr(databusAddr),
      .databusRdata(databusRdata),
      .databusWdata(databusWdata),
      .databusWstrb(databusWstrb),
      .out0(out0)
   );

   // memory answers in the same cycle
   assign databusRdata = extMem[databusAddr[9:0]];

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic testRow_t fillRow(input ioAddr_t extAddr, input memAddr_t intAddr,
                                        input ioSize_t size);
      testRow_t r;
      r = '0;
      r.mode = MODE_FILL;
      r.cfg.ext.extAddr = extAddr;
      r.cfg.ext.intAddr = intAddr;
      r.cfg.ext.size = size;
      return r;
   endfunction

   function automatic testRow_t readRow(input memAddr_t start, input memAddr_t iterations,
                                        input memAddr_t shift, input period_t period,
                                        input memAddr_t incr, input memAddr_t iterations2,
                                        input memAddr_t incr2, input period_t delay,
                                        input logic reverse);
      testRow_t r;
      r = '0;
      r.mode = MODE_READ;
      r.cfg.gen.start = start;
      r.cfg.gen.iterations = iterations;
      r.cfg.gen.shift = shift;
      r.cfg.gen.period = period;
      r.cfg.gen.incr = incr;
      r.cfg.gen.iterations2 = iterations2;
      r.cfg.gen.incr2 = incr2;
      r.cfg.gen.delay = delay;
      r.cfg.gen.reverse = reverse;
      return r;
   endfunction

   function automatic testRow_t zeroRow();
      testRow_t r;
      r = '0;
      r.mode = MODE_ZERO;
      return r;
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                 input logic [31:0] actVal);
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
      errors++;
   endtask

   // bus monitor for the coming edge, then step to 1 ns after it
   task automatic tick();
      logic [31:0] r;
      if (databusValid)
      begin
         if (!busAllowed)
         begin
            $display("bus request at %0t in a row with size zero", $time);
            errors++;
         end
         else if (databusReady)
         begin
            if (databusAddr !== busNext)
               reportMismatch("databusAddr", busNext, databusAddr);
            busNext = busNext + 32'd1;
            hsCount++;
         end
      end
      @(posedge clk);
      #1;
      r = $urandom;
      databusReady = r[0];
   endtask

   // j outer, i middle, p fastest
   task automatic buildExpected(input genCfg_t g);
      memAddr_t a;
      int sum;
      expQ.delete();
      for (int j = 0; j < int'(g.iterations2); j++)
      begin
         for (int i = 0; i < int'(g.iterations); i++)
         begin
            for (int p = 0; p < int'(g.period); p++)
            begin
               sum = int'(g.start) + j * int'(g.incr2) + i * int'(g.shift)
                     + p * int'(g.incr);
               a = memAddr_t'(sum);
               if (g.reverse)
                  a = {<<{a}};
               expQ.push_back(modelRam[a]);
            end
         end
      end
   endtask

   task automatic runRow(input int idx, input testRow_t row);
      int errBefore;
      int cycles;
      data_t out0Before;
      string modeName;
      errBefore = errors;
      out0Before = out0;
      busAllowed = (row.mode == MODE_FILL);
      busNext = row.cfg.ext.extAddr;
      hsCount = 0;
      if (row.mode == MODE_READ)
         buildExpected(row.cfg.gen);
      cfg = row.cfg;
      run = 1'b1;
      tick();
      run = 1'b0;
      if (row.mode == MODE_READ)
      begin
         // item 0 shows after edge E0+3+delay
         repeat (3 + int'(row.cfg.gen.delay)) tick();
         for (int n = 0; n < expQ.size(); n++)
         begin
            if (n > 0)
               tick();
            if (out0 !== expQ[n])
               reportMismatch("out0", expQ[n], out0);
         end
         if (done !== 1'b1)
         begin
            $display("test %0d: done was not high with the last item", idx);
            errors++;
         end
      end
      cycles = 0;
      while (done !== 1'b1 && cycles < TIMEOUT)
      begin
         tick();
         cycles++;
      end
      if (done !== 1'b1)
      begin
         $display("test %0d: done did not rise within %0d cycles", idx, TIMEOUT);
         errors++;
      end
      if (row.mode == MODE_ZERO && cycles > 2)
      begin
         $display("test %0d: done took %0d cycles after run", idx, cycles);
         errors++;
      end
      if (row.mode != MODE_READ && out0 !== out0Before)
         reportMismatch("out0", out0Before, out0);
      if (row.mode == MODE_FILL)
      begin
         if (hsCount != int'(row.cfg.ext.size))
            reportMismatch("handshake count", 32'(row.cfg.ext.size), 32'(hsCount));
         for (int k = 0; k < int'(row.cfg.ext.size); k++)
            modelRam[row.cfg.ext.intAddr + memAddr_t'(k)] =
               (row.cfg.ext.extAddr + ioAddr_t'(k)) ^ 32'hA5A5_0000;
      end
      if (row.mode == MODE_FILL)
         modeName = "fill";
      else if (row.mode == MODE_READ)
         modeName = "read";
      else
         modeName = "zero";
      if (errors == errBefore)
      begin
         $display("test %0d %s: passed", idx, modeName);
         passed++;
      end
      else
      begin
         $display("test %0d %s: failed with %0d errors", idx, modeName, errors - errBefore);
         failed++;
      end
   endtask

   initial
   begin
      void'($urandom(32'he1c14ded));
      arstN = 1'b0;
      run = 1'b0;
      cfg = '0;
      databusReady = 1'b0;
      errors = 0;
      passed = 0;
      failed = 0;
      hsCount = 0;
      busAllowed = 1'b0;
      busNext = '0;
      for (int a = 0; a < 1024; a++)
         extMem[a] = data_t'(a) ^ 32'hA5A5_0000;

      testTable[0] = fillRow(32'h100, 8'd0, 9'd64);
      testTable[1] = readRow(8'd0, 8'd64, 8'd1, 5'd1, 8'd0, 8'd1, 8'd0, 5'd0, 1'b0);
      testTable[2] = fillRow(32'h2C0, 8'd128, 9'd64);
      testTable[3] = readRow(8'd128, 8'd64, 8'd1, 5'd1, 8'd0, 8'd1, 8'd0, 5'd0, 1'b0);
      // full RAM, so every reversed address holds data
      testTable[4] = fillRow(32'h200, 8'd0, 9'd256);
      testTable[5] = readRow(8'd8, 8'd3, 8'd16, 5'd4, 8'd2, 8'd2, 8'd64, 5'd3, 1'b0);
      testTable[6] = readRow(8'd0, 8'd64, 8'd1, 5'd1, 8'd0, 8'd1, 8'd0, 5'd0, 1'b1);
      testTable[7] = zeroRow();

      repeat (10) @(posedge clk);
      #1;
      arstN = 1'b1;
      if (databusValid !== 1'b0)
         reportMismatch("databusValid", 32'd0, 32'(databusValid));
      if (done !== 1'b0)
         reportMismatch("done", 32'd0, 32'(done));

      for (int idx = 0; idx < NUM_ROWS; idx++)
         runRow(idx, testTable[idx]);

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               NUM_ROWS, passed, failed, errors);
      if (errors == 0 && failed == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/vRead_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module vReadAssert
   import vReadPkg::*;
(
   input wire                     clk,
   input wire                     arstN,
   input wire                     run,
   input wire                     done,
   input wire                     databusValid,
   input wire                     databusReady,
   input wire ioAddr_t            databusAddr,
   input wire data_t              databusWdata,
   input wire [`VR_DATA_W/8-1:0]  databusWstrb
);

   // request holds while the memory stalls
   property validHolds;
      @(posedge clk) disable iff (!arstN)
         databusValid && !databusReady |=> databusValid && $stable(databusAddr);
   endproperty

   validHoldA: assert property (validHolds)
      else $error("databusValid dropped or address moved under back-pressure");

   writeTieA: assert property (@(posedge clk) disable iff (!arstN)
                               databusWstrb == '0 && databusWdata == '0)
      else $error("write strobes or write data not zero");

   // a new run clears done
   doneClearA: assert property (@(posedge clk) disable iff (!arstN) run |=> !done)
      else $error("done high in the cycle after run");

endmodule

bind vRead vReadAssert checks_i (
   .clk(clk),
   .arstN(arstN),
   .run(run),
   .done(done),
   .databusValid(databusValid),
   .databusReady(databusReady),
   .databusAddr(databusAddr),
   .databusWdata(databusWdata),
   .databusWstrb(databusWstrb)
);

`default_nettype wire
